//--- hw/dsi_settings.svh
`ifndef DSI_SETTINGS_SVH
`define DSI_SETTINGS_SVH

// active line payload, 4 pixels at 24 bpp
`define DSI_BYTES_PER_LINE 12
`define DSI_WORDS_PER_LINE (`DSI_BYTES_PER_LINE / 4)

`define DSI_BLANK_CYCLES   8   // every blanking wait
`define DSI_HBP_CYCLES     4   // hss to data header

// lines per frame region
`define DSI_VSA_LINES      1
`define DSI_VBP_LINES      1
`define DSI_ACT_LINES      2
`define DSI_VFP_LINES      1

`define DSI_FIFO_DEPTH     4   // entries in the word fifo

`endif

//--- hw/dsi_pkg.sv
`default_nettype none

package dsi_pkg;

  typedef enum logic [5:0] {
    DT_VSS   = 6'h01,
    DT_HSS   = 6'h21,
    DT_PPS24 = 6'h3E
  } data_type_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_SEND_VSS,
    ST_WAIT_VSS,
    ST_SEND_HSS_VSA,
    ST_WAIT_VSA,
    ST_SEND_HSS_VBP,
    ST_WAIT_VBP,
    ST_SEND_HSS_ACT,
    ST_WAIT_HBP,
    ST_SEND_HDR,
    ST_SEND_DATA,
    ST_SEND_CRC,
    ST_WAIT_HFP,
    ST_SEND_HSS_VFP,
    ST_WAIT_VFP
  } frame_state_e;

  typedef struct packed {
    logic        half;   // only bytes 0 and 1 valid
    logic [31:0] data;
  } pkt_word_t;

  typedef struct packed {
    logic [3:0]  strb;   // one per lane
    logic [31:0] data;   // byte 0 on lane 0
  } phy_word_t;

  typedef struct packed {
    logic        line_ready;
    logic [31:0] data;
  } pix_word_t;

endpackage

`default_nettype wire

//--- hw/dsi_ecc.sv
`default_nettype none
`timescale 1ns/1ps

module dsi_ecc (
  input  wire  [23:0] header,
  output logic [7:0]  ecc
);

  logic [23:0] d;

  assign d = header;

  // hamming parity per the dsi header table
  assign ecc[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13]
                ^ d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];

  assign ecc[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14]
                ^ d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];

  assign ecc[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15]
                ^ d[18] ^ d[20] ^ d[21] ^ d[22];

  assign ecc[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15]
                ^ d[19] ^ d[20] ^ d[21] ^ d[23];

  assign ecc[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18]
                ^ d[19] ^ d[20] ^ d[22] ^ d[23];

  assign ecc[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17]
                ^ d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];

  assign ecc[7:6] = 2'b00;   // unused in 24-bit headers

endmodule

`default_nettype wire

//--- hw/dsi_crc16.sv
`default_nettype none
`timescale 1ns/1ps

module dsi_crc16 (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         clear,
  input  wire         update,
  input  wire  [31:0] data,
  output logic [15:0] crc
);

  logic [15:0] crc_q;

  // reflected x^16+x^12+x^5+1, one bit at a time, lsb first
  function automatic logic [15:0] crc_step(input logic [15:0] crc_in, input logic [31:0] d);
    logic [15:0] c;
    logic        fb;
    c = crc_in;
    for (int i = 0; i < 32; i++)
    begin
      fb = c[0] ^ d[i];
      c  = {1'b0, c[15:1]};
      if (fb)
        c = c ^ 16'h8408;
    end
    return c;
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      crc_q <= 16'hFFFF;
    else if (clear)
      crc_q <= 16'hFFFF;   // preset before each long packet
    else if (update)
      crc_q <= crc_step(crc_q, data);
  end

  assign crc = crc_q;

  a_clear_update_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(clear && update));

endmodule

`default_nettype wire

//--- hw/dsi_frame_ctrl.sv
`default_nettype none
`timescale 1ns/1ps
`include "dsi_settings.svh"

module dsi_frame_ctrl (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     enable,
  input  wire dsi_pkg::pix_word_t pix,
  input  wire                     pix_valid,
  output logic                    pix_ready,
  output dsi_pkg::pkt_word_t      pkt,
  output logic                    pkt_valid,
  input  wire                     pkt_ready,
  output logic                    frame_active
);

  dsi_pkg::frame_state_e state;
  dsi_pkg::frame_state_e state_next;
  dsi_pkg::data_type_e   dtype;

  logic [15:0] blank_cnt;
  logic [15:0] line_cnt;
  logic [15:0] word_cnt;
  logic [15:0] word_count;
  logic [23:0] header;
  logic [7:0]  ecc;
  logic [15:0] crc;
  logic        xfer;
  logic        blank_done;
  logic        last_line;
  logic        line_end;

  assign xfer       = pkt_valid && pkt_ready;
  assign blank_done = (blank_cnt == 16'd0);
  assign last_line  = (line_cnt == 16'd1);
  assign line_end   = blank_done && (state inside {dsi_pkg::ST_WAIT_VSA, dsi_pkg::ST_WAIT_VBP,
                                                   dsi_pkg::ST_WAIT_HFP, dsi_pkg::ST_WAIT_VFP});

  always_comb
  begin
    state_next = state;
    case (state)
      dsi_pkg::ST_IDLE:
        if (enable && pix.line_ready)
          state_next = dsi_pkg::ST_SEND_VSS;
      dsi_pkg::ST_SEND_VSS:     state_next = xfer ? dsi_pkg::ST_WAIT_VSS : state;
      dsi_pkg::ST_WAIT_VSS:     state_next = blank_done ? dsi_pkg::ST_SEND_HSS_VSA : state;
      dsi_pkg::ST_SEND_HSS_VSA: state_next = xfer ? dsi_pkg::ST_WAIT_VSA : state;
      dsi_pkg::ST_WAIT_VSA:
        if (blank_done)
          state_next = last_line ? dsi_pkg::ST_SEND_HSS_VBP : dsi_pkg::ST_SEND_HSS_VSA;
      dsi_pkg::ST_SEND_HSS_VBP: state_next = xfer ? dsi_pkg::ST_WAIT_VBP : state;
      dsi_pkg::ST_WAIT_VBP:
        if (blank_done)
          state_next = last_line ? dsi_pkg::ST_SEND_HSS_ACT : dsi_pkg::ST_SEND_HSS_VBP;
      dsi_pkg::ST_SEND_HSS_ACT: state_next = xfer ? dsi_pkg::ST_WAIT_HBP : state;
      dsi_pkg::ST_WAIT_HBP:     state_next = blank_done ? dsi_pkg::ST_SEND_HDR : state;
      dsi_pkg::ST_SEND_HDR:     state_next = xfer ? dsi_pkg::ST_SEND_DATA : state;
      dsi_pkg::ST_SEND_DATA:
        if (xfer && word_cnt == 16'd1)
          state_next = dsi_pkg::ST_SEND_CRC;
      dsi_pkg::ST_SEND_CRC:     state_next = xfer ? dsi_pkg::ST_WAIT_HFP : state;
      dsi_pkg::ST_WAIT_HFP:
        if (blank_done)
          state_next = last_line ? dsi_pkg::ST_SEND_HSS_VFP : dsi_pkg::ST_SEND_HSS_ACT;
      dsi_pkg::ST_SEND_HSS_VFP: state_next = xfer ? dsi_pkg::ST_WAIT_VFP : state;
      dsi_pkg::ST_WAIT_VFP:
        if (blank_done)
          state_next = last_line ? dsi_pkg::ST_IDLE : dsi_pkg::ST_SEND_HSS_VFP;
      default:                  state_next = dsi_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= dsi_pkg::ST_IDLE;
      blank_cnt <= 16'd0;
      line_cnt  <= 16'd0;
      word_cnt  <= 16'd0;
    end
    else
    begin
      state <= state_next;
      // waits are only entered from send states, where the counter rests at zero
      if (state_next == dsi_pkg::ST_WAIT_HBP && state != dsi_pkg::ST_WAIT_HBP)
        blank_cnt <= 16'(`DSI_HBP_CYCLES - 1);
      else if (state_next != state && (state_next inside {dsi_pkg::ST_WAIT_VSS,
               dsi_pkg::ST_WAIT_VSA, dsi_pkg::ST_WAIT_VBP, dsi_pkg::ST_WAIT_HFP,
               dsi_pkg::ST_WAIT_VFP}))
        blank_cnt <= 16'(`DSI_BLANK_CYCLES - 1);
      else if (!blank_done)
        blank_cnt <= blank_cnt - 16'd1;

      if (state == dsi_pkg::ST_WAIT_VSS && blank_done)
        line_cnt <= 16'(`DSI_VSA_LINES);
      else if (line_end && last_line && state == dsi_pkg::ST_WAIT_VSA)
        line_cnt <= 16'(`DSI_VBP_LINES);
      else if (line_end && last_line && state == dsi_pkg::ST_WAIT_VBP)
        line_cnt <= 16'(`DSI_ACT_LINES);
      else if (line_end && last_line && state == dsi_pkg::ST_WAIT_HFP)
        line_cnt <= 16'(`DSI_VFP_LINES);
      else if (line_end)
        line_cnt <= line_cnt - 16'd1;

      if (state == dsi_pkg::ST_SEND_HDR && xfer)
        word_cnt <= 16'(`DSI_WORDS_PER_LINE);
      else if (state == dsi_pkg::ST_SEND_DATA && xfer)
        word_cnt <= word_cnt - 16'd1;
    end
  end

  always_comb
  begin
    dtype      = dsi_pkg::DT_HSS;
    word_count = 16'd0;   // short packets carry zero
    if (state == dsi_pkg::ST_SEND_VSS)
      dtype = dsi_pkg::DT_VSS;
    else if (state == dsi_pkg::ST_SEND_HDR)
    begin
      dtype      = dsi_pkg::DT_PPS24;
      word_count = 16'(`DSI_BYTES_PER_LINE);
    end
  end

  assign header = {word_count, 2'b00, dtype};   // virtual channel 0

  dsi_ecc u_ecc (
    .header (header),
    .ecc    (ecc)
  );

  dsi_crc16 u_crc (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (state == dsi_pkg::ST_SEND_HDR),
    .update (state == dsi_pkg::ST_SEND_DATA && xfer),
    .data   (pix.data),
    .crc    (crc)
  );

  always_comb
  begin
    pkt.half = 1'b0;
    pkt.data = {ecc, header};
    if (state == dsi_pkg::ST_SEND_DATA)
      pkt.data = pix.data;
    else if (state == dsi_pkg::ST_SEND_CRC)
    begin
      pkt.half = 1'b1;
      pkt.data = {16'h0000, crc};
    end
  end

  always_comb
  begin
    case (state)
      dsi_pkg::ST_SEND_VSS, dsi_pkg::ST_SEND_HSS_VSA, dsi_pkg::ST_SEND_HSS_VBP,
      dsi_pkg::ST_SEND_HSS_ACT, dsi_pkg::ST_SEND_HDR, dsi_pkg::ST_SEND_HSS_VFP,
      dsi_pkg::ST_SEND_CRC:  pkt_valid = 1'b1;
      dsi_pkg::ST_SEND_DATA: pkt_valid = pix_valid;
      default:               pkt_valid = 1'b0;
    endcase
  end

  assign pix_ready    = (state == dsi_pkg::ST_SEND_DATA) && pkt_ready;
  assign frame_active = (state != dsi_pkg::ST_IDLE);

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {[dsi_pkg::ST_IDLE : dsi_pkg::ST_WAIT_VFP]});

  a_pix_ready_payload: assert property (@(posedge clk) disable iff (!rst_n)
    pix_ready |-> (word_cnt != 16'd0) && (word_cnt <= 16'(`DSI_WORDS_PER_LINE)));

endmodule

`default_nettype wire

//--- hw/dsi_word_fifo.sv
`default_nettype none
`timescale 1ns/1ps
`include "dsi_settings.svh"

module dsi_word_fifo (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire dsi_pkg::pkt_word_t in_word,
  input  wire                     in_valid,
  output logic                    in_ready,
  output dsi_pkg::pkt_word_t      out_word,
  output logic                    out_valid,
  input  wire                     out_ready
);

  localparam int AW = $clog2(`DSI_FIFO_DEPTH);
  localparam logic [AW:0] DEPTH = (AW + 1)'(`DSI_FIFO_DEPTH);

  dsi_pkg::pkt_word_t mem [`DSI_FIFO_DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          wr_en;
  logic          rd_en;

  assign in_ready  = (count != DEPTH);
  assign out_valid = (count != '0);
  assign out_word  = mem[rd_ptr];   // show-ahead
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= in_word;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == AW'(`DSI_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == AW'(`DSI_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (wr_en && !rd_en)
        count <= count + 1'b1;
      else if (rd_en && !wr_en)
        count <= count - 1'b1;
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    (count == DEPTH && !rd_en) |=> $stable(wr_ptr));

  a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
    (count == '0) |=> $stable(rd_ptr));

endmodule

`default_nettype wire

//--- hw/dsi_lane_packer.sv
`default_nettype none
`timescale 1ns/1ps

module dsi_lane_packer (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire  [2:0]              lanes,
  input  wire dsi_pkg::pkt_word_t in_word,
  input  wire                     in_valid,
  output logic                    in_ready,
  output dsi_pkg::phy_word_t      phy,
  output logic                    phy_valid,
  input  wire                     phy_ready
);

  logic [63:0] sreg;
  logic [3:0]  byte_cnt;
  logic [2:0]  lanes_q;
  logic [3:0]  lane_bytes;
  logic [3:0]  in_bytes;
  logic [3:0]  out_bytes;
  logic [3:0]  keep_bytes;
  logic [63:0] sreg_shift;
  logic [31:0] in_data;
  logic        phy_xfer;
  logic        rd_en;

  assign lane_bytes = {1'b0, lanes_q};
  assign in_bytes   = in_word.half ? 4'd2 : 4'd4;
  assign in_data    = in_word.half ? {16'h0000, in_word.data[15:0]} : in_word.data;

  // full beat, or flush what is left once the fifo runs dry
  assign phy_valid  = (byte_cnt != 4'd0) && ((byte_cnt >= lane_bytes) || !in_valid);
  assign out_bytes  = (byte_cnt >= lane_bytes) ? lane_bytes : byte_cnt;
  assign phy_xfer   = phy_valid && phy_ready;
  assign keep_bytes = byte_cnt - (phy_xfer ? out_bytes : 4'd0);
  assign sreg_shift = phy_xfer ? (sreg >> {out_bytes, 3'b000}) : sreg;
  assign in_ready   = (keep_bytes <= 4'd4);   // room for a full word
  assign rd_en      = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sreg     <= '0;
      byte_cnt <= 4'd0;
      lanes_q  <= 3'd4;
    end
    else
    begin
      sreg     <= rd_en ? (sreg_shift | ({32'h0, in_data} << {keep_bytes, 3'b000})) : sreg_shift;
      byte_cnt <= keep_bytes + (rd_en ? in_bytes : 4'd0);
      if (byte_cnt == 4'd0 && !in_valid)
        lanes_q <= lanes;   // only between bursts
    end
  end

  always_comb
  begin
    phy.data = sreg[31:0];
    case (out_bytes)
      4'd1:    phy.strb = 4'b0001;
      4'd2:    phy.strb = 4'b0011;
      4'd3:    phy.strb = 4'b0111;
      4'd4:    phy.strb = 4'b1111;
      default: phy.strb = 4'b0000;
    endcase
  end

  a_byte_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    byte_cnt <= 4'd8);

endmodule

`default_nettype wire

//--- hw/dsi_tx_assembler.sv
`default_nettype none
`timescale 1ns/1ps

module dsi_tx_assembler (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     enable,
  input  wire  [2:0]              lanes,
  input  wire dsi_pkg::pix_word_t pix,
  input  wire                     pix_valid,
  output logic                    pix_ready,
  output dsi_pkg::phy_word_t      phy,
  output logic                    phy_valid,
  input  wire                     phy_ready,
  output logic                    busy
);

  dsi_pkg::pkt_word_t pkt;
  dsi_pkg::pkt_word_t fifo_word;
  logic               pkt_valid;
  logic               pkt_ready;
  logic               fifo_valid;
  logic               fifo_ready;
  logic               frame_active;

  dsi_frame_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable       (enable),
    .pix          (pix),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .pkt          (pkt),
    .pkt_valid    (pkt_valid),
    .pkt_ready    (pkt_ready),
    .frame_active (frame_active)
  );

  dsi_word_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_word   (pkt),
    .in_valid  (pkt_valid),
    .in_ready  (pkt_ready),
    .out_word  (fifo_word),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  dsi_lane_packer u_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .lanes     (lanes),
    .in_word   (fifo_word),
    .in_valid  (fifo_valid),
    .in_ready  (fifo_ready),
    .phy       (phy),
    .phy_valid (phy_valid),
    .phy_ready (phy_ready)
  );

  assign busy = frame_active || fifo_valid || phy_valid;   // drops after the last beat

endmodule

`default_nettype wire

//--- tb/tb_dsi_tx.sv
`default_nettype none
`timescale 1ns/1ps
`include "dsi_settings.svh"

module tb_dsi_tx;

  localparam int NPIX        = `DSI_ACT_LINES * `DSI_WORDS_PER_LINE;
  localparam int NROWS       = 7;
  localparam int FRAME_LIMIT = 3000;   // cycles per frame
  localparam int IDLE_WINDOW = 200;

  // syndrome of each header bit, bit 23 leftmost
  localparam logic [143:0] ECC_CODES = {
    6'h3B, 6'h37, 6'h2F, 6'h1F, 6'h38, 6'h34, 6'h32, 6'h31, 6'h2C, 6'h2A, 6'h29, 6'h26,
    6'h25, 6'h23, 6'h1C, 6'h1A, 6'h19, 6'h16, 6'h15, 6'h13, 6'h0E, 6'h0D, 6'h0B, 6'h07};

  typedef struct packed {
    logic [2:0] lanes;
    logic       rand_ready;   // random phy_ready duty
    logic       enable;
  } row_t;

  logic               clk;
  logic               rst_n;
  logic               enable;
  logic [2:0]         lanes;
  dsi_pkg::pix_word_t pix;
  logic               pix_valid;
  logic               pix_ready;
  dsi_pkg::phy_word_t phy;
  logic               phy_valid;
  logic               phy_ready;
  logic               busy;

  integer      seed;
  row_t        rows [NROWS];
  logic [31:0] pix_mem [NPIX];
  logic [7:0]  exp_q [$];
  logic [7:0]  got_q [$];

  dsi_tx_assembler UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .lanes     (lanes),
    .pix       (pix),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .phy       (phy),
    .phy_valid (phy_valid),
    .phy_ready (phy_ready),
    .busy      (busy)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  function automatic logic [7:0] header_ecc(input logic [23:0] hdr);
    logic [5:0] p;
    p = 6'd0;
    for (int i = 0; i < 24; i++)
      if (hdr[i])
        p = p ^ ECC_CODES[6 * i +: 6];
    return {2'b00, p};
  endfunction

  // lsb first, reflected polynomial
  function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    c = crc ^ {8'h00, b};
    for (int k = 0; k < 8; k++)
      c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
    return c;
  endfunction

  function automatic void push_header(input logic [5:0] dt, input logic [15:0] wc);
    logic [23:0] hdr;
    hdr = {wc, 2'b00, dt};   // virtual channel 0
    exp_q.push_back(hdr[7:0]);
    exp_q.push_back(hdr[15:8]);
    exp_q.push_back(hdr[23:16]);
    exp_q.push_back(header_ecc(hdr));
  endfunction

  function automatic void build_reference();
    logic [15:0] crc;
    logic [7:0]  b;
    exp_q.delete();
    push_header(dsi_pkg::DT_VSS, 16'd0);
    for (int l = 0; l < `DSI_VSA_LINES; l++)
      push_header(dsi_pkg::DT_HSS, 16'd0);
    for (int l = 0; l < `DSI_VBP_LINES; l++)
      push_header(dsi_pkg::DT_HSS, 16'd0);
    for (int l = 0; l < `DSI_ACT_LINES; l++)
    begin
      push_header(dsi_pkg::DT_HSS, 16'd0);
      push_header(dsi_pkg::DT_PPS24, 16'(`DSI_BYTES_PER_LINE));
      crc = 16'hFFFF;
      for (int k = 0; k < `DSI_BYTES_PER_LINE; k++)
      begin
        b = pix_mem[l * `DSI_WORDS_PER_LINE + k / 4][8 * (k % 4) +: 8];
        exp_q.push_back(b);
        crc = crc_byte(crc, b);
      end
      exp_q.push_back(crc[7:0]);
      exp_q.push_back(crc[15:8]);
    end
    for (int l = 0; l < `DSI_VFP_LINES; l++)
      push_header(dsi_pkg::DT_HSS, 16'd0);
  endfunction

  task automatic collect_beat(input logic [2:0] lane_cnt);
    int         n;
    logic [3:0] s1;
    n  = 0;
    s1 = phy.strb + 4'd1;
    for (int i = 0; i < 4; i++)
    begin
      if (phy.strb[i])
      begin
        got_q.push_back(phy.data[8 * i +: 8]);
        n++;
      end
    end
    check_value("phy.strb contiguous", (phy.strb != 4'd0) && ((s1 & phy.strb) == 4'd0), 1);
    if (UUT.fifo_valid)
      check_value("phy.strb count", n, lane_cnt);
    else
      check_value("phy.strb count within lanes", n <= lane_cnt, 1);   // flush beat
  endtask

  task automatic check_stream();
    int          p;
    logic [23:0] hdr;
    logic [15:0] wc;
    logic [15:0] crc;
    check_value("phy byte count", got_q.size(), exp_q.size());
    p = 0;
    while (p < got_q.size())
    begin
      hdr = {got_q[p + 2], got_q[p + 1], got_q[p]};
      check_value("header ecc", got_q[p + 3], header_ecc(hdr));
      wc = 16'd0;
      if (hdr[5:0] == dsi_pkg::DT_PPS24)
      begin
        wc = hdr[23:8];
        check_value("pps24 word count", wc, `DSI_BYTES_PER_LINE);
        crc = 16'hFFFF;
        for (int i = 0; i < wc; i++)
          crc = crc_byte(crc, got_q[p + 4 + i]);
        check_value("payload crc", {got_q[p + 5 + wc], got_q[p + 4 + wc]}, crc);
        wc = wc + 16'd2;
      end
      p = p + 4 + wc;
    end
    for (int i = 0; i < exp_q.size(); i++)
      check_value($sformatf("phy byte %0d", i), got_q[i], exp_q[i]);
  endtask

  task automatic run_row(input row_t r);
    int          cycles;
    int          idx;
    logic        started;
    logic        done;
    logic        take;
    logic [31:0] rnd;
    for (int i = 0; i < NPIX; i++)
      pix_mem[i] = $random(seed);
    build_reference();
    got_q.delete();
    idx     = 0;
    cycles  = 0;
    started = 1'b0;
    done    = 1'b0;
    $display("row: %0d lanes, random ready %0d, enable %0d", r.lanes, r.rand_ready, r.enable);
    @(posedge clk);
    lanes     <= r.lanes;
    phy_ready <= 1'b1;
    @(posedge clk);
    enable    <= r.enable;
    pix_valid <= 1'b1;
    pix       <= {1'b1, pix_mem[0]};
    if (!r.enable)
    begin
      for (int c = 0; c < IDLE_WINDOW; c++)
      begin
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("phy_valid", phy_valid, 0);
        check_value("pix_ready", pix_ready, 0);
      end
      @(posedge clk);
      pix_valid <= 1'b0;
    end
    else
    begin
      while (!done)
      begin
        @(negedge clk);
        cycles++;
        if (cycles > FRAME_LIMIT)
          report_timeout("frame did not finish within the cycle limit");
        if (phy_valid && phy_ready)
          collect_beat(r.lanes);
        take    = pix_valid && pix_ready;
        done    = started && !busy;
        started = started || busy;
        @(posedge clk);
        rnd = $random(seed);
        phy_ready <= r.rand_ready ? rnd[0] : 1'b1;
        if (started)
          enable <= 1'b0;   // one frame only
        if (take)
        begin
          idx = idx + 1;
          if (idx < NPIX)
            pix <= {1'b1, pix_mem[idx]};
          else
          begin
            pix_valid <= 1'b0;
            pix       <= {1'b1, 32'h0};
          end
        end
      end
      check_stream();
    end
  endtask

  initial
  begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    enable    = 1'b0;
    lanes     = 3'd4;
    pix       = '0;
    pix_valid = 1'b0;
    phy_ready = 1'b0;
    seed      = 32'h88ec71f3;
    rows[0]   = {3'd4, 1'b0, 1'b1};
    rows[1]   = {3'd1, 1'b0, 1'b1};
    rows[2]   = {3'd2, 1'b0, 1'b1};
    rows[3]   = {3'd4, 1'b1, 1'b1};
    rows[4]   = {3'd1, 1'b1, 1'b1};
    rows[5]   = {3'd2, 1'b1, 1'b1};
    rows[6]   = {3'd4, 1'b0, 1'b0};   // idle with line_ready high
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("pix_ready", pix_ready, 0);
    check_value("pkt_valid", UUT.pkt_valid, 0);
    check_value("phy_valid", phy_valid, 0);
    check_value("busy", busy, 0);
    for (int r = 0; r < NROWS; r++)
      run_row(rows[r]);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/dsi_pkg.sv
hw/dsi_ecc.sv
hw/dsi_crc16.sv
hw/dsi_frame_ctrl.sv
hw/dsi_word_fifo.sv
hw/dsi_lane_packer.sv
hw/dsi_tx_assembler.sv
tb/tb_dsi_tx.sv
